//--- include/vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Horizontal raster, in pixel clocks
`define H_VISIBLE 640
`define H_FRONT 18
`define H_SYNC 92
`define H_BACK 50
`define H_TOTAL (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical raster, in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 12
`define V_BACK 33
`define V_TOTAL (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// Square sprite side in pixels
`define SPRITE_SIZE 16

// Scan position to output port, in clocks
`define PIPE_LATENCY 2

`endif

//--- source/vga_pkg.sv
`default_nettype none

`include "vga_macros.svh"

package vga_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [9:0] h_count;
        logic [9:0] v_count;
        logic       visible;
        logic       hsync_n;                // Active low
        logic       vsync_n;                // Active low
    } scan_pos_t;

    typedef struct packed {
        logic opaque;
        rgb_t color;
    } layer_pixel_t;

    typedef struct packed {
        logic [9:0] x;                      // Left edge
        logic [9:0] y;                      // Top edge
        logic       enable;
        rgb_t       color;
    } sprite_cfg_t;

    localparam rgb_t rgb_black = 24'h000000;
    localparam rgb_t rgb_white = 24'hffffff;

    // Outlined square, border two pixels thick; bit c is column c
    localparam logic [`SPRITE_SIZE-1:0] sprite_bitmap [`SPRITE_SIZE] = '{
        16'hffff, 16'hffff,
        16'hc003, 16'hc003, 16'hc003, 16'hc003,
        16'hc003, 16'hc003, 16'hc003, 16'hc003,
        16'hc003, 16'hc003, 16'hc003, 16'hc003,
        16'hffff, 16'hffff
    };

endpackage

`default_nettype wire

//--- source/vga_timing.sv
`default_nettype none

`include "vga_macros.svh"

module vga_timing (
    input  wire                 CLK,
    input  wire                 arst_n,
    output vga_pkg::scan_pos_t  scan
);

    import vga_pkg::*;

    localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       h_last;
    logic       v_last;

    assign h_last = (h_count == 10'(`H_TOTAL - 1));
    assign v_last = (v_count == 10'(`V_TOTAL - 1));

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_last) begin
                h_count <= '0;
                if (v_last) begin
                    v_count <= '0;                  // Next frame
                end else begin
                    v_count <= v_count + 10'd1;
                end
            end else begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    // Decoded straight from the counters, no register stage
    always_comb begin
        scan.h_count = h_count;
        scan.v_count = v_count;
        scan.visible = (h_count < 10'(`H_VISIBLE)) && (v_count < 10'(`V_VISIBLE));
        scan.hsync_n = !((h_count >= 10'(H_SYNC_START)) && (h_count < 10'(H_SYNC_END)));
        scan.vsync_n = !((v_count >= 10'(V_SYNC_START)) && (v_count < 10'(V_SYNC_END)));
    end

endmodule

`default_nettype wire

//--- source/stripe_background.sv
`default_nettype none

module stripe_background (
    input  wire                 CLK,
    input  wire                 arst_n,
    input  vga_pkg::scan_pos_t  scan,
    output vga_pkg::rgb_t       bg_pixel
);

    import vga_pkg::*;

    logic [9:0] h;
    logic [9:0] v;
    logic [4:0] h_mod;
    logic       tooth;
    logic       white;

    assign h = scan.h_count;
    assign v = scan.v_count;

    // Teeth repeat every 30 pixels, 14 wide, sixteen of them
    assign h_mod = 5'(h % 10'd30);
    assign tooth = (h < 10'd470) && (h_mod >= 5'd6) && (h_mod <= 5'd19);

    always_comb begin
        if (!scan.visible) begin
            white = 1'b0;                   // Blanking
        end else if (v < 10'd128) begin
            white = 1'b0;
        end else if (v < 10'd160) begin
            white = tooth;                  // Row of teeth
        end else if (v < 10'd192) begin
            white = 1'b0;
        end else if (v < 10'd224) begin
            white = 1'b1;
        end else if (v < 10'd256) begin
            white = 1'b0;
        end else if (v < 10'd288) begin
            white = 1'b1;
        end else if (v < 10'd320) begin
            white = 1'b0;
        end else if (v < 10'd352) begin
            white = 1'b1;
        end else if (v < 10'd368) begin
            white = 1'b0;                   // Narrow gap
        end else if (v < 10'd416) begin
            white = 1'b1;                   // Wide band
        end else begin
            white = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            bg_pixel <= rgb_black;
        end else begin
            bg_pixel <= white ? rgb_white : rgb_black;
        end
    end

endmodule

`default_nettype wire

//--- source/sprite_engine.sv
`default_nettype none

`include "vga_macros.svh"

module sprite_engine (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  vga_pkg::scan_pos_t      scan,
    input  vga_pkg::sprite_cfg_t    sprite_cfg,
    output vga_pkg::layer_pixel_t   spr_pixel
);

    import vga_pkg::*;

    sprite_cfg_t cfg_q;
    sprite_cfg_t cfg_cur;
    logic        frame_start;
    logic [10:0] dx;
    logic [10:0] dy;
    logic        in_window;
    logic [3:0]  row;
    logic [3:0]  col;
    logic        hit;

    assign frame_start = (scan.h_count == 10'd0) && (scan.v_count == 10'd0);

    // Position only changes between frames
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q <= '0;
        end else if (frame_start) begin
            cfg_q <= sprite_cfg;
        end
    end

    // Pixel (0,0) already belongs to the new frame
    assign cfg_cur = frame_start ? sprite_cfg : cfg_q;

    // One extra bit so a negative offset never looks like a hit
    assign dx = {1'b0, scan.h_count} - {1'b0, cfg_cur.x};
    assign dy = {1'b0, scan.v_count} - {1'b0, cfg_cur.y};

    assign in_window = (dx < 11'(`SPRITE_SIZE)) && (dy < 11'(`SPRITE_SIZE));
    assign row       = dy[3:0];
    assign col       = dx[3:0];

    assign hit = cfg_cur.enable && scan.visible && in_window && sprite_bitmap[row][col];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            spr_pixel.opaque <= 1'b0;
            spr_pixel.color  <= rgb_black;
        end else begin
            spr_pixel.opaque <= hit;
            spr_pixel.color  <= hit ? cfg_cur.color : rgb_black;   // Transparent is black
        end
    end

endmodule

`default_nettype wire

//--- source/pixel_compositor.sv
`default_nettype none

`include "vga_macros.svh"

module pixel_compositor (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  vga_pkg::scan_pos_t      scan,
    input  vga_pkg::rgb_t           bg_pixel,
    input  vga_pkg::layer_pixel_t   spr_pixel,
    output logic                    hsync_n,
    output logic                    vsync_n,
    output vga_pkg::rgb_t           color
);

    import vga_pkg::*;

    logic [`PIPE_LATENCY-1:0] hs_pipe;
    logic [`PIPE_LATENCY-1:0] vs_pipe;
    logic                     visible_d;        // Aligned with the layer outputs
    rgb_t                     mixed;

    assign mixed = spr_pixel.opaque ? spr_pixel.color : bg_pixel;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            hs_pipe   <= '1;                    // Syncs idle high
            vs_pipe   <= '1;
            visible_d <= 1'b0;
            color     <= rgb_black;
        end else begin
            hs_pipe   <= {hs_pipe[`PIPE_LATENCY-2:0], scan.hsync_n};
            vs_pipe   <= {vs_pipe[`PIPE_LATENCY-2:0], scan.vsync_n};
            visible_d <= scan.visible;
            color     <= visible_d ? mixed : rgb_black;
        end
    end

    assign hsync_n = hs_pipe[`PIPE_LATENCY-1];
    assign vsync_n = vs_pipe[`PIPE_LATENCY-1];

endmodule

`default_nettype wire

//--- source/video_top.sv
`default_nettype none

module video_top (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  vga_pkg::sprite_cfg_t    sprite_cfg,
    output logic                    hsync_n,
    output logic                    vsync_n,
    output vga_pkg::rgb_t           color
);

    import vga_pkg::*;

    scan_pos_t    scan;
    rgb_t         bg_pixel;
    layer_pixel_t spr_pixel;

    vga_timing timing_i (
        .CLK    (CLK),
        .arst_n (arst_n),
        .scan   (scan)
    );

    stripe_background background_i (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .scan     (scan),
        .bg_pixel (bg_pixel)
    );

    sprite_engine sprite_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .scan       (scan),
        .sprite_cfg (sprite_cfg),
        .spr_pixel  (spr_pixel)
    );

    pixel_compositor compositor_i (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .scan      (scan),
        .bg_pixel  (bg_pixel),
        .spr_pixel (spr_pixel),
        .hsync_n   (hsync_n),
        .vsync_n   (vsync_n),
        .color     (color)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

endmodule

`default_nettype wire

//--- verif/video_sva.sv
`default_nettype none

`include "vga_macros.svh"

module video_sva (
    input wire                          CLK,
    input wire                          arst_n,
    input wire vga_pkg::sprite_cfg_t    sprite_cfg,
    input wire                          hsync_n,
    input wire                          vsync_n,
    input wire vga_pkg::rgb_t           color
);

    import vga_pkg::*;

    int          fail_count = 0;            // Watched by the testbench
    logic [9:0]  ref_h;
    logic [9:0]  ref_v;
    sprite_cfg_t frame_cfg;                 // Sprite setup of the frame on the ports
    int          dx;
    int          dy;
    logic        ref_visible;
    logic        on_sprite;
    logic        white;

    // Position of the pixel now at the ports, PIPE_LATENCY behind the DUT counters
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ref_h     <= 10'(`H_TOTAL - `PIPE_LATENCY);
            ref_v     <= 10'(`V_TOTAL - 1);
            frame_cfg <= '0;
        end else begin
            if (ref_h == 10'(`H_TOTAL - `PIPE_LATENCY) && ref_v == 10'(`V_TOTAL - 1)) begin
                frame_cfg <= sprite_cfg;    // DUT scan sits at (0,0) here
            end
            if (ref_h == 10'(`H_TOTAL - 1)) begin
                ref_h <= '0;
                ref_v <= (ref_v == 10'(`V_TOTAL - 1)) ? '0 : ref_v + 10'd1;
            end else begin
                ref_h <= ref_h + 10'd1;
            end
        end
    end

    always_comb begin
        dx          = int'(ref_h) - int'(frame_cfg.x);
        dy          = int'(ref_v) - int'(frame_cfg.y);
        ref_visible = (ref_h < `H_VISIBLE) && (ref_v < `V_VISIBLE);
        // Square outline, two pixels thick
        on_sprite   = frame_cfg.enable && dx >= 0 && dx < `SPRITE_SIZE
                      && dy >= 0 && dy < `SPRITE_SIZE
                      && (dx < 2 || dx >= `SPRITE_SIZE - 2 || dy < 2 || dy >= `SPRITE_SIZE - 2);
        if (ref_v >= 128 && ref_v < 160) begin
            white = (ref_h < 470) && (ref_h % 30 >= 6) && (ref_h % 30 <= 19);   // Teeth
        end else begin
            white = (ref_v >= 192 && ref_v < 224) || (ref_v >= 256 && ref_v < 288)
                    || (ref_v >= 320 && ref_v < 352) || (ref_v >= 368 && ref_v < 416);
        end
    end

    a_hsync: assert property (@(posedge CLK) disable iff (!arst_n)
        hsync_n == !(ref_h >= `H_VISIBLE + `H_FRONT && ref_h < `H_TOTAL - `H_BACK))
    else begin
        fail_count++;
        $error("hsync_n wrong at reference h=%0d", $sampled(ref_h));
    end

    a_vsync: assert property (@(posedge CLK) disable iff (!arst_n)
        vsync_n == !(ref_v >= `V_VISIBLE + `V_FRONT && ref_v < `V_TOTAL - `V_BACK))
    else begin
        fail_count++;
        $error("vsync_n wrong at reference line %0d", $sampled(ref_v));
    end

    a_blanking: assert property (@(posedge CLK) disable iff (!arst_n)
        !ref_visible |-> color == 24'h000000)
    else begin
        fail_count++;
        $error("color not black in blanking at h=%0d v=%0d", $sampled(ref_h), $sampled(ref_v));
    end

    a_sprite: assert property (@(posedge CLK) disable iff (!arst_n)
        ref_visible && on_sprite |-> color == frame_cfg.color)
    else begin
        fail_count++;
        $error("sprite pixel wrong at h=%0d v=%0d", $sampled(ref_h), $sampled(ref_v));
    end

    a_background: assert property (@(posedge CLK) disable iff (!arst_n)
        ref_visible && !on_sprite |-> color == (white ? 24'hffffff : 24'h000000))
    else begin
        fail_count++;
        $error("background wrong at h=%0d v=%0d", $sampled(ref_h), $sampled(ref_v));
    end

endmodule

`default_nettype wire

//--- verif/video_tb.sv
`default_nettype none

`include "vga_macros.svh"

module video_tb;

    import vga_pkg::*;

    logic        CLK;
    logic        arst_n;
    sprite_cfg_t sprite_cfg;
    logic        hsync_n;
    logic        vsync_n;
    rgb_t        color;
    logic [31:0] lfsr_state;

    tb_clock #(.PERIOD(8)) clock_i (.CLK(CLK));

    video_top dut_i (.*);

    bind video_top video_sva sva_i (.*);

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
        end
    endtask

    task automatic random_sprite(output sprite_cfg_t cfg);
        logic [31:0] bits;
        cfg.enable = 1'b1;
        take_bits(10, bits);
        cfg.x = 10'(bits % (`H_VISIBLE - `SPRITE_SIZE));   // Fully on screen
        take_bits(9, bits);
        // Lower half, below every line where the setup changes
        cfg.y = 10'(`V_VISIBLE / 2 + bits % (`V_VISIBLE / 2 - `SPRITE_SIZE));
        take_bits(24, bits);
        cfg.color = bits[23:0];
    endtask

    task automatic wait_vsync(input logic level);
        int cycles;
        cycles = 0;
        while (vsync_n !== level) begin
            @(negedge CLK);
            cycles++;
            if (cycles > `H_TOTAL * `V_TOTAL) begin
                report_failure($sformatf("timeout waiting for vsync_n to become %0b", level));
            end
        end
    endtask

    // Counts falling edges of hsync_n
    task automatic wait_lines(input int lines);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = hsync_n;
        while (seen < lines) begin
            @(negedge CLK);
            cycles++;
            if (prev && !hsync_n) begin
                seen++;
                cycles = 0;
            end
            prev = hsync_n;
            if (cycles > 2 * `H_TOTAL) begin
                report_failure("timeout waiting for an hsync_n pulse");
            end
        end
    endtask

    always @(dut_i.sva_i.fail_count) begin
        if (dut_i.sva_i.fail_count != 0) begin
            report_failure($sformatf("mismatch at time %0t: a video_sva assertion failed", $time));
        end
    end

    initial begin
        arst_n     = 1'b0;
        sprite_cfg = '0;                    // Frame 0 without sprite
        lfsr_state = 32'h6f39d429;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        wait_lines(200);
        random_sprite(sprite_cfg);          // Changed mid frame 0 and shown from frame 1
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        wait_lines(`V_BACK + 240);          // Middle of frame 1
        random_sprite(sprite_cfg);          // Moves in frame 2
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        wait_vsync(1'b0);                   // Frame 2 visible area done
        if (dut_i.sva_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure($sformatf("mismatch at time %0t: %0d assertion failures",
                                     $time, dut_i.sva_i.fail_count));
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/vga_pkg.sv
source/vga_timing.sv
source/stripe_background.sv
source/sprite_engine.sv
source/pixel_compositor.sv
source/video_top.sv
verif/tb_clock.sv
verif/video_sva.sv
verif/video_tb.sv

//--- Bender.yml
package:
  name: vga_sprite

sources:
  - include_dirs:
      - include
    files:
      - source/vga_pkg.sv
      - source/vga_timing.sv
      - source/stripe_background.sv
      - source/sprite_engine.sv
      - source/pixel_compositor.sv
      - source/video_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock.sv
      - verif/video_sva.sv
      - verif/video_tb.sv
